// ==== design/rv_slice_cfg.svh ====
`ifndef RV_SLICE_CFG_SVH
`define RV_SLICE_CFG_SVH

// core width, rv64i
`define XLEN            64

// x0..x31
`define REG_ADDR_WIDTH  5

// first fetch address, zero-extended to XLEN where used
`define RESET_PC        32'h8000_0000

`endif

// ==== design/rv_slice_pkg.sv ====
`include "rv_slice_cfg.svh"

package rv_slice_pkg;

    typedef struct packed {
        logic [6:0]                 funct7;
        logic [`REG_ADDR_WIDTH-1:0] rs2;
        logic [`REG_ADDR_WIDTH-1:0] rs1;
        logic [2:0]                 funct3;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic [6:0]                 opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]                imm12;
        logic [`REG_ADDR_WIDTH-1:0] rs1;
        logic [2:0]                 funct3;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic [6:0]                 opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [19:0]                imm20;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic [6:0]                 opcode;
    } u_fmt_t;

    // one instruction word, three ways to look at it
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        u_fmt_t u_fmt;
    } inst_u;

    typedef enum logic [2:0] {
        ALU_ADD   = 3'd0,
        ALU_SUB   = 3'd1,
        ALU_AND   = 3'd2,
        ALU_OR    = 3'd3,
        ALU_XOR   = 3'd4,
        ALU_SLL   = 3'd5,
        ALU_SRL   = 3'd6,
        ALU_PASS2 = 3'd7    // lui, src2 straight through
    } alu_op_e;

    typedef struct packed {
        logic                       valid;
        logic [`XLEN-1:0]           pc;
        alu_op_e                    alu_op;
        logic [`XLEN-1:0]           src1;
        logic [`XLEN-1:0]           src2;
        logic                       reg_wen;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic                       ebreak;
        logic                       illegal;
        inst_u                      inst;       // raw word kept for debug
    } id_ex_t;

    typedef struct packed {
        logic [`XLEN-1:0]           pc;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic                       reg_wen;
        logic [`XLEN-1:0]           data;
        logic                       ebreak;
        logic                       illegal;
    } wb_t;

endpackage

// ==== design/inst_decoder.sv ====
`timescale 1ns/1ps
`include "rv_slice_cfg.svh"

module inst_decoder (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       inst_req_i,
    input  rv_slice_pkg::inst_u        inst_i,
    input  logic [`XLEN-1:0]           rs1_data_i,
    input  logic [`XLEN-1:0]           rs2_data_i,
    output logic                       inst_ack_o,
    output logic [`REG_ADDR_WIDTH-1:0] rs1_addr_o,
    output logic [`REG_ADDR_WIDTH-1:0] rs2_addr_o,
    output rv_slice_pkg::id_ex_t       id_rec_o
);
    import rv_slice_pkg::*;

    localparam logic [6:0]  OPC_OP     = 7'b0110011;
    localparam logic [6:0]  OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0]  OPC_LUI    = 7'b0110111;
    localparam logic [6:0]  OPC_SYSTEM = 7'b1110011;
    localparam logic [31:0] INST_EBREAK = 32'h0010_0073;

    logic             accept;
    logic [`XLEN-1:0] pc_q;
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_u;

    assign accept     = inst_req_i & ~inst_ack_o;  // req seen, not yet acked
    assign rs1_addr_o = inst_i.r_fmt.rs1;
    assign rs2_addr_o = inst_i.r_fmt.rs2;
    assign imm_i = {{(`XLEN-12){inst_i.i_fmt.imm12[11]}}, inst_i.i_fmt.imm12};
    assign imm_u = {{(`XLEN-32){inst_i.u_fmt.imm20[19]}}, inst_i.u_fmt.imm20, 12'b0};

    // four-phase ack and pc counter
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            inst_ack_o <= 1'b0;
            pc_q       <= {{(`XLEN-32){1'b0}}, `RESET_PC};
        end else if (accept) begin
            inst_ack_o <= 1'b1;
            pc_q       <= pc_q + `XLEN'd4;
        end else if (!inst_req_i) begin
            inst_ack_o <= 1'b0;                     // source has let go
        end
    end

    always_comb begin
        id_rec_o         = '0;
        id_rec_o.valid   = accept;
        id_rec_o.pc      = pc_q;
        id_rec_o.rd      = inst_i.r_fmt.rd;
        id_rec_o.inst    = inst_i;
        id_rec_o.src1    = rs1_data_i;
        id_rec_o.src2    = rs2_data_i;
        id_rec_o.alu_op  = ALU_ADD;
        id_rec_o.reg_wen = 1'b1;
        case (inst_i.r_fmt.opcode)
            OPC_OP: begin
                if (inst_i.r_fmt.funct7 == 7'b0100000 && inst_i.r_fmt.funct3 == 3'b000) begin
                    id_rec_o.alu_op = ALU_SUB;
                end else if (inst_i.r_fmt.funct7 == 7'b0000000) begin
                    case (inst_i.r_fmt.funct3)
                        3'b000:  id_rec_o.alu_op = ALU_ADD;
                        3'b001:  id_rec_o.alu_op = ALU_SLL;
                        3'b100:  id_rec_o.alu_op = ALU_XOR;
                        3'b101:  id_rec_o.alu_op = ALU_SRL;
                        3'b110:  id_rec_o.alu_op = ALU_OR;
                        3'b111:  id_rec_o.alu_op = ALU_AND;
                        default: id_rec_o.illegal = 1'b1;
                    endcase
                    if (id_rec_o.alu_op == ALU_SLL || id_rec_o.alu_op == ALU_SRL) begin
                        id_rec_o.src2 = {{(`XLEN-6){1'b0}}, rs2_data_i[5:0]};  // shamt only
                    end
                end else begin
                    id_rec_o.illegal = 1'b1;
                end
            end
            OPC_OP_IMM: begin
                id_rec_o.src2 = imm_i;
                case (inst_i.i_fmt.funct3)
                    3'b000:  id_rec_o.alu_op = ALU_ADD;
                    3'b100:  id_rec_o.alu_op = ALU_XOR;
                    3'b110:  id_rec_o.alu_op = ALU_OR;
                    3'b111:  id_rec_o.alu_op = ALU_AND;
                    default: id_rec_o.illegal = 1'b1;   // shifts-imm not supported
                endcase
            end
            OPC_LUI: begin
                id_rec_o.alu_op = ALU_PASS2;
                id_rec_o.src2   = imm_u;
            end
            OPC_SYSTEM: begin
                id_rec_o.reg_wen = 1'b0;
                if (inst_i == INST_EBREAK) id_rec_o.ebreak = 1'b1;
                else                        id_rec_o.illegal = 1'b1;
            end
            default: id_rec_o.illegal = 1'b1;
        endcase
        if (id_rec_o.illegal) id_rec_o.reg_wen = 1'b0;
    end

endmodule

// ==== design/reg_file.sv ====
`timescale 1ns/1ps
`include "rv_slice_cfg.svh"

module reg_file (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic [`REG_ADDR_WIDTH-1:0] rs1_addr_i,
    input  logic [`REG_ADDR_WIDTH-1:0] rs2_addr_i,
    input  rv_slice_pkg::wb_t          wb_i,
    input  logic                       wb_valid_i,
    output logic [`XLEN-1:0]           rs1_data_o,
    output logic [`XLEN-1:0]           rs2_data_o
);

    logic [`XLEN-1:0] regs [32];
    logic             wen;

    assign wen = wb_valid_i && wb_i.reg_wen && (wb_i.rd != '0);  // x0 never written

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen) begin
            regs[wb_i.rd] <= wb_i.data;
        end
    end

    // write-through so a same-cycle read sees the new value
    assign rs1_data_o = (rs1_addr_i == '0)                ? '0 :
                        (wen && rs1_addr_i == wb_i.rd)    ? wb_i.data :
                                                            regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0)                ? '0 :
                        (wen && rs2_addr_i == wb_i.rd)    ? wb_i.data :
                                                            regs[rs2_addr_i];

endmodule

// ==== design/id_ex_regs.sv ====
`timescale 1ns/1ps
`include "rv_slice_cfg.svh"

module id_ex_regs (
    input  logic                 clk,
    input  logic                 rst_n,
    input  rv_slice_pkg::id_ex_t id_rec_i,
    output rv_slice_pkg::id_ex_t ex_rec_o
);

    // free-running stage, a bubble just carries valid low
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_rec_o    <= '0;
            ex_rec_o.pc <= {{(`XLEN-32){1'b0}}, `RESET_PC};
        end else begin
            ex_rec_o <= id_rec_i;
        end
    end

endmodule

// ==== design/exec_unit.sv ====
`timescale 1ns/1ps
`include "rv_slice_cfg.svh"

module exec_unit (
    input  logic                 clk,
    input  logic                 rst_n,
    input  rv_slice_pkg::id_ex_t ex_rec_i,
    output rv_slice_pkg::wb_t    wb_o,
    output logic                 wb_valid_o
);
    import rv_slice_pkg::*;

    logic [`XLEN-1:0] alu_res;
    wb_t              wb_next;

    always_comb begin
        case (ex_rec_i.alu_op)
            ALU_ADD:   alu_res = ex_rec_i.src1 + ex_rec_i.src2;
            ALU_SUB:   alu_res = ex_rec_i.src1 - ex_rec_i.src2;
            ALU_AND:   alu_res = ex_rec_i.src1 & ex_rec_i.src2;
            ALU_OR:    alu_res = ex_rec_i.src1 | ex_rec_i.src2;
            ALU_XOR:   alu_res = ex_rec_i.src1 ^ ex_rec_i.src2;
            ALU_SLL:   alu_res = ex_rec_i.src1 << ex_rec_i.src2;
            ALU_SRL:   alu_res = ex_rec_i.src1 >> ex_rec_i.src2;  // logical
            ALU_PASS2: alu_res = ex_rec_i.src2;
            default:   alu_res = '0;
        endcase
    end

    always_comb begin
        wb_next.pc      = ex_rec_i.pc;
        wb_next.rd      = ex_rec_i.rd;
        wb_next.data    = alu_res;
        wb_next.ebreak  = ex_rec_i.ebreak;
        wb_next.illegal = ex_rec_i.illegal;
        wb_next.reg_wen = ex_rec_i.reg_wen & ~ex_rec_i.ebreak & ~ex_rec_i.illegal;
    end

    // one-cycle strobe per valid record
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid_o <= 1'b0;
        end else begin
            wb_valid_o <= ex_rec_i.valid;
        end
    end

    // result holds until the next instruction
    always_ff @(posedge clk) begin
        if (ex_rec_i.valid) begin
            wb_o <= wb_next;
        end
    end

endmodule

// ==== design/rv_slice_top.sv ====
`timescale 1ns/1ps
`include "rv_slice_cfg.svh"

module rv_slice_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                inst_req_i,
    input  rv_slice_pkg::inst_u inst_i,
    output logic                inst_ack_o,
    output rv_slice_pkg::wb_t   wb_o,
    output logic                wb_valid_o
);
    import rv_slice_pkg::*;

    id_ex_t                     id_rec;
    id_ex_t                     ex_rec;
    logic [`REG_ADDR_WIDTH-1:0] rs1_addr;
    logic [`REG_ADDR_WIDTH-1:0] rs2_addr;
    logic [`XLEN-1:0]           rs1_data;
    logic [`XLEN-1:0]           rs2_data;

    inst_decoder u_inst_decoder (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_req_i (inst_req_i),
        .inst_i     (inst_i),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .inst_ack_o (inst_ack_o),
        .rs1_addr_o (rs1_addr),
        .rs2_addr_o (rs2_addr),
        .id_rec_o   (id_rec)
    );

    reg_file u_reg_file (
        .clk        (clk),
        .rst_n      (rst_n),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .wb_i       (wb_o),         // writeback port fed from the exec result
        .wb_valid_i (wb_valid_o),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data)
    );

    id_ex_regs u_id_ex_regs (
        .clk      (clk),
        .rst_n    (rst_n),
        .id_rec_i (id_rec),
        .ex_rec_o (ex_rec)
    );

    exec_unit u_exec_unit (
        .clk        (clk),
        .rst_n      (rst_n),
        .ex_rec_i   (ex_rec),
        .wb_o       (wb_o),
        .wb_valid_o (wb_valid_o)
    );

endmodule

// ==== verif/tb_rv_slice.sv ====
`timescale 1ns/1ps
`include "rv_slice_cfg.svh"

module tb_rv_slice;
    import rv_slice_pkg::*;

    localparam int NUM_INSTS      = 65;
    localparam int TIMEOUT_CYCLES = NUM_INSTS * 10 + 200;    // margin covers reset

    localparam logic [6:0] OP_R   = 7'b0110011;
    localparam logic [6:0] OP_I   = 7'b0010011;
    localparam logic [6:0] OP_LUI = 7'b0110111;
    localparam logic [6:0] OP_SYS = 7'b1110011;

    logic             clk;
    logic             rst_n;
    logic             inst_req_i;
    inst_u            inst_i;
    logic             inst_ack_o;
    wb_t              wb_o;
    logic             wb_valid_o;

    logic [`XLEN-1:0] mregs [32];   // reference register file
    logic [`XLEN-1:0] exp_pc;
    int               err_count;
    int               tests_passed;
    int               tests_failed;
    int               seed;

    rv_slice_top DUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_req_i (inst_req_i),
        .inst_i     (inst_i),
        .inst_ack_o (inst_ack_o),
        .wb_o       (wb_o),
        .wb_valid_o (wb_valid_o)
    );

    always #4 clk = ~clk;

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OP_R};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, OP_I};
    endfunction

    function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, OP_LUI};
    endfunction

    // expected writeback per the rv64i spec
    function automatic wb_t predict(input logic [31:0] w);
        wb_t              e;
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        logic [`XLEN-1:0] imm;
        e         = '0;
        a         = mregs[w[19:15]];
        b         = mregs[w[24:20]];
        imm       = {{(`XLEN-12){w[31]}}, w[31:20]};
        e.pc      = exp_pc;
        e.rd      = w[11:7];
        e.reg_wen = 1'b1;
        case (w[6:0])
            OP_R: begin
                case ({w[31:25], w[14:12]})
                    {7'h00, 3'd0}: e.data = a + b;
                    {7'h20, 3'd0}: e.data = a - b;
                    {7'h00, 3'd7}: e.data = a & b;
                    {7'h00, 3'd6}: e.data = a | b;
                    {7'h00, 3'd4}: e.data = a ^ b;
                    {7'h00, 3'd1}: e.data = a << b[5:0];
                    {7'h00, 3'd5}: e.data = a >> b[5:0];
                    default:       e.illegal = 1'b1;
                endcase
            end
            OP_I: begin
                case (w[14:12])
                    3'd0:    e.data = a + imm;
                    3'd4:    e.data = a ^ imm;
                    3'd6:    e.data = a | imm;
                    3'd7:    e.data = a & imm;
                    default: e.illegal = 1'b1;
                endcase
            end
            OP_LUI:  e.data = {{(`XLEN-32){w[31]}}, w[31:12], 12'h000};
            OP_SYS: begin
                if (w == 32'h0010_0073) begin
                    e.ebreak = 1'b1;
                end else begin
                    e.illegal = 1'b1;
                end
            end
            default: e.illegal = 1'b1;
        endcase
        if (e.ebreak || e.illegal) begin
            e.reg_wen = 1'b0;
        end
        return e;
    endfunction

    function automatic void retire(input wb_t e);
        if (e.reg_wen && e.rd != 5'd0) begin
            mregs[e.rd] = e.data;               // x0 stays zero
        end
        exp_pc = exp_pc + `XLEN'd4;
    endfunction

    task automatic compare_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("error: %s expected %b actual %b", name, expected, actual);
            err_count++;
        end
    endtask

    task automatic compare_wb(input string name, input wb_t expected, input wb_t actual);
        wb_t e_m;
        wb_t a_m;
        e_m = expected;
        a_m = actual;
        if (!expected.reg_wen) begin
            e_m.data = '0;                      // nothing written, data unused
            a_m.data = '0;
        end
        if (a_m !== e_m) begin
            $display("error: %s expected %h actual %h", name, expected, actual);
            err_count++;
        end
    endtask

    // four-phase handshake, then check the result against the model
    task automatic send_inst(input string name, input logic [31:0] word);
        wb_t expected;
        expected = predict(word);
        @(posedge clk);
        inst_req_i <= 1'b1;
        inst_i     <= word;
        @(negedge clk);
        while (!inst_ack_o) @(negedge clk);
        compare_bit({name, " strobe early"}, 1'b0, wb_valid_o);    // one edge after accept
        @(posedge clk);
        inst_req_i <= 1'b0;
        @(negedge clk);
        compare_bit({name, " strobe"}, 1'b1, wb_valid_o);          // two edges after accept
        compare_wb(name, expected, wb_o);
        @(negedge clk);
        compare_bit({name, " strobe width"}, 1'b0, wb_valid_o);
        compare_bit({name, " ack release"}, 1'b0, inst_ack_o);
        retire(expected);
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (err_count == errs_before) begin
            $display("test %s: ok", name);
            tests_passed++;
        end else begin
            $display("test %s: %0d errors", name, err_count - errs_before);
            tests_failed++;
        end
    endtask

    task automatic test_reset();
        int e0;
        e0 = err_count;
        @(negedge clk);
        compare_bit("reset ack", 1'b0, inst_ack_o);
        compare_bit("reset strobe", 1'b0, wb_valid_o);
        send_inst("reset first pc", enc_i(12'd5, 5'd0, 3'd0, 5'd1));
        send_inst("reset next pc", enc_i(12'd7, 5'd1, 3'd0, 5'd1));
        report_test("reset", e0);
    endtask

    task automatic test_imm();
        int e0;
        e0 = err_count;
        send_inst("addi neg", enc_i(12'hfff, 5'd0, 3'd0, 5'd2));
        send_inst("andi", enc_i(12'h0f0, 5'd2, 3'd7, 5'd3));
        send_inst("ori neg", enc_i(12'hff0, 5'd3, 3'd6, 5'd4));
        send_inst("xori", enc_i(12'h7ff, 5'd2, 3'd4, 5'd5));
        send_inst("addi min", enc_i(12'h800, 5'd5, 3'd0, 5'd6));
        send_inst("lui neg", enc_u(20'h80000, 5'd7));
        send_inst("lui pos", enc_u(20'h12345, 5'd8));
        report_test("immediate ops", e0);
    endtask

    task automatic test_reg();
        int e0;
        e0 = err_count;
        send_inst("chain seed", enc_i(12'h123, 5'd0, 3'd0, 5'd1));
        send_inst("add", enc_r(7'h00, 5'd8, 5'd1, 3'd0, 5'd10));
        send_inst("sub", enc_r(7'h20, 5'd7, 5'd10, 3'd0, 5'd11));
        send_inst("and", enc_r(7'h00, 5'd2, 5'd11, 3'd7, 5'd12));
        send_inst("or", enc_r(7'h00, 5'd4, 5'd12, 3'd6, 5'd13));
        send_inst("xor", enc_r(7'h00, 5'd5, 5'd13, 3'd4, 5'd14));
        send_inst("sll", enc_r(7'h00, 5'd1, 5'd14, 3'd1, 5'd15));
        send_inst("srl", enc_r(7'h00, 5'd3, 5'd15, 3'd5, 5'd16));
        report_test("register ops", e0);
    endtask

    task automatic test_x0();
        int e0;
        e0 = err_count;
        send_inst("addi to x0", enc_i(12'h055, 5'd0, 3'd0, 5'd0));
        send_inst("add to x0", enc_r(7'h00, 5'd2, 5'd2, 3'd0, 5'd0));
        send_inst("x0 read", enc_r(7'h00, 5'd0, 5'd0, 3'd0, 5'd9));
        send_inst("x0 or", enc_r(7'h00, 5'd8, 5'd0, 3'd6, 5'd9));
        report_test("x0 writes", e0);
    endtask

    task automatic test_trap();
        int e0;
        e0 = err_count;
        send_inst("ebreak", 32'h0010_0073);
        send_inst("bad opcode", 32'h0bad_c0de);                     // rd is x1
        send_inst("sra illegal", enc_r(7'h20, 5'd1, 5'd1, 3'd5, 5'd2));
        send_inst("readback", enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd20));
        report_test("ebreak and illegal", e0);
    endtask

    task automatic test_random();
        int          e0;
        int          pick;
        logic [31:0] r;
        logic [31:0] r2;
        logic [31:0] word;
        e0 = err_count;
        for (int i = 0; i < 40; i++) begin
            r    = $random(seed);
            r2   = $random(seed);
            pick = int'(r2[3:0]) % 12;
            case (pick)
                0:       word = enc_r(7'h00, r[14:10], r[9:5], 3'd0, r[4:0]);
                1:       word = enc_r(7'h20, r[14:10], r[9:5], 3'd0, r[4:0]);
                2:       word = enc_r(7'h00, r[14:10], r[9:5], 3'd7, r[4:0]);
                3:       word = enc_r(7'h00, r[14:10], r[9:5], 3'd6, r[4:0]);
                4:       word = enc_r(7'h00, r[14:10], r[9:5], 3'd4, r[4:0]);
                5:       word = enc_r(7'h00, r[14:10], r[9:5], 3'd1, r[4:0]);
                6:       word = enc_r(7'h00, r[14:10], r[9:5], 3'd5, r[4:0]);
                7:       word = enc_i(r[26:15], r[9:5], 3'd0, r[4:0]);
                8:       word = enc_i(r[26:15], r[9:5], 3'd7, r[4:0]);
                9:       word = enc_i(r[26:15], r[9:5], 3'd6, r[4:0]);
                10:      word = enc_i(r[26:15], r[9:5], 3'd4, r[4:0]);
                default: word = enc_u(r[31:12], r[4:0]);
            endcase
            send_inst($sformatf("random %0d", i), word);
        end
        report_test("random alu", e0);
    endtask

    // watchdog
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout: run did not finish in %0d cycles, handshake stuck", TIMEOUT_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        inst_req_i   = 1'b0;
        inst_i       = '0;
        seed         = 32'h899c;
        err_count    = 0;
        tests_passed = 0;
        tests_failed = 0;
        exp_pc       = {{(`XLEN-32){1'b0}}, `RESET_PC};
        for (int i = 0; i < 32; i++) begin
            mregs[i] = '0;
        end
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        test_reset();
        test_imm();
        test_reg();
        test_x0();
        test_trap();
        test_random();
        $display("summary: %0d passed, %0d failed", tests_passed, tests_failed);
        if (tests_failed == 0 && err_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== rv_slice.f ====
+incdir+design
design/rv_slice_pkg.sv
design/inst_decoder.sv
design/reg_file.sv
design/id_ex_regs.sv
design/exec_unit.sv
design/rv_slice_top.sv
verif/tb_rv_slice.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds the rv_slice testbench with verilator and runs it

cd "$(dirname "$0")" || exit 1
LOG=sim.log

rm -rf obj_dir "$LOG"
verilator --binary --timing --top-module tb_rv_slice -f rv_slice.f -o tb_rv_slice > "$LOG" 2>&1 \
    && ./obj_dir/tb_rv_slice >> "$LOG" 2>&1 \
    || echo "TESTS FAILED" >> "$LOG"

cat "$LOG"
if grep -q "TESTS FAILED" "$LOG"; then
    exit 1
fi
exit 0
